/* Makefile */
TOP := icache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/icache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_checker
    import mem_bus_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      fetch_valid,
    input logic      ready,
    input logic      resp_valid,
    input logic      mem_req_valid,
    input logic      mem_rvalid,
    input mem_beat_t mem_beat
);

    // a line request stays open until its last beat
    logic req_open;
    int   fail_count = 0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_open <= 1'b0;
        end else if (mem_req_valid) begin
            req_open <= 1'b1;
        end else if (mem_rvalid && mem_beat.last) begin
            req_open <= 1'b0;
        end
    end

    fetch_needs_ready: assert property (@(posedge clk) disable iff (!rst)
        fetch_valid |-> ready)
        else begin
            $error("fetch strobe while ready is low");
            fail_count++;
        end

    resp_single_cycle: assert property (@(posedge clk) disable iff (!rst)
        resp_valid |=> !resp_valid)
        else begin
            $error("resp_valid high in two consecutive cycles");
            fail_count++;
        end

    one_open_request: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid |-> !req_open)
        else begin
            $error("second memory request before the last beat");
            fail_count++;
        end

endmodule

bind icache_top icache_checker protocol_check (
    .clk(clk),
    .rst(rst),
    .fetch_valid(fetch_valid),
    .ready(ready),
    .resp_valid(resp_valid),
    .mem_req_valid(mem_req_valid),
    .mem_rvalid(mem_rvalid),
    .mem_beat(mem_beat)
);

`default_nettype wire

/* dv/icache_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_monitor
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_valid,
    input  fetch_req_t                   fetch_req,
    input  logic                         ready,
    input  logic                         resp_valid,
    input  fetch_resp_t                  fetch_resp,
    input  logic                         mem_req_valid,
    input  mem_req_t                     mem_req,
    input  logic                         fence_req,
    input  logic                         fence_done,
    input  logic [`ICACHE_WORD_BITS-1:0] exp_word,
    input  logic                         exp_hit,
    output int                           data_errors,
    output int                           flag_errors,
    output int                           proto_errors
);

    localparam logic [`ICACHE_ADDR_BITS-1:0] LINE_MASK =
        {`ICACHE_ADDR_BITS{1'b1}} << `ICACHE_OFFSET_BITS;

    logic                         pending;
    logic                         after_reset;
    logic                         fence_busy;
    fetch_req_t                   cur_req;
    logic [`ICACHE_WORD_BITS-1:0] cur_word;
    logic                         cur_hit;
    int                           latency;
    int                           req_count;
    int                           fence_cycles;

    always @(posedge clk) begin
        if (!rst) begin
            pending      = 1'b0;
            after_reset  = 1'b1;
            fence_busy   = 1'b0;
            data_errors  = 0;
            flag_errors  = 0;
            proto_errors = 0;
        end else begin
            if (after_reset && (!ready || resp_valid || mem_req_valid || fence_done)) begin
                proto_errors++;
                $display("ERROR at %0t: ports not idle after reset", $time);
            end
            after_reset = 1'b0;
            // the only legal request is the line of the pending miss
            if (mem_req_valid && (!pending || mem_req.addr != (cur_req.addr & LINE_MASK))) begin
                proto_errors++;
                $display("ERROR at %0t: memory request for %h does not match a pending fetch",
                         $time, mem_req.addr);
            end
            if (resp_valid && !pending) begin
                proto_errors++;
                $display("ERROR at %0t: response without a fetch", $time);
            end
            if (pending) begin
                req_count += mem_req_valid ? 1 : 0;
                if (resp_valid) begin
                    pending = 1'b0;
                    if (fetch_resp.word !== cur_word) begin
                        data_errors++;
                        $display("ERROR at %0t: fetch %h returned %h, expected %h",
                                 $time, cur_req.addr, fetch_resp.word, cur_word);
                    end
                    if (cur_hit ? (latency != 1 || req_count != 0) : (req_count != 1)) begin
                        flag_errors++;
                        $display("ERROR at %0t: fetch %h expected a %s, saw %0d requests in %0d cycles",
                                 $time, cur_req.addr, cur_hit ? "hit" : "miss", req_count, latency);
                    end
                end else begin
                    latency++;
                end
            end
            if (fetch_valid && ready) begin
                pending   = 1'b1;
                cur_req   = fetch_req;
                cur_word  = exp_word;
                cur_hit   = exp_hit;
                latency   = 1;
                req_count = 0;
            end
            if (fence_busy) begin
                fence_cycles++;
                if (fence_done) begin
                    fence_busy = 1'b0;
                    if (fence_cycles > `ICACHE_SETS + 2) begin
                        proto_errors++;
                        $display("ERROR at %0t: fence took %0d cycles", $time, fence_cycles);
                    end
                end
            end else if (fence_done) begin
                proto_errors++;
                $display("ERROR at %0t: fence_done without a fence", $time);
            end
            if (fence_req) begin
                fence_busy   = 1'b1;
                fence_cycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/icache_stimulus.txt */
# op    addr      expected  hit (1 = hit, 0 = miss)
# word at byte address A is ~A, fence rows carry zeros
fetch 00001018 ffffefe7 0
fetch 00001010 ffffefef 1
fetch 0000101c ffffefe3 1
fetch 00001014 ffffefeb 1
fetch 00002024 ffffdfdb 0
fetch 00002020 ffffdfdf 1
fetch 00abc0f0 ff543f0f 0
fetch 00abc0f4 ff543f0b 1
fetch 00000000 ffffffff 0
fetch 00000104 fffffefb 0
fetch 00000208 fffffdf7 0
fetch 0000030c fffffcf3 0
fetch 00000400 fffffbff 0
fetch 00000000 ffffffff 0
fetch 00000304 fffffcfb 1
fetch 0000020c fffffdf3 1
fetch 00000104 fffffefb 0
fence 00000000 00000000 0
fetch 00001018 ffffefe7 0
fetch 0000030c fffffcf3 0
fetch 00abc0f4 ff543f0b 0
fetch 00000308 fffffcf7 1

/* dv/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_tb
    import icache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int WAIT_LIMIT = 64;

    logic                         clk;
    logic                         rst;
    logic                         fetch_valid;
    fetch_req_t                   fetch_req;
    logic                         ready;
    logic                         resp_valid;
    fetch_resp_t                  fetch_resp;
    logic                         mem_req_valid;
    mem_req_t                     mem_req;
    logic                         mem_rvalid;
    mem_beat_t                    mem_beat;
    logic                         fence_req;
    logic                         fence_done;
    logic [`ICACHE_WORD_BITS-1:0] exp_word;
    logic                         exp_hit;
    int                           data_errors;
    int                           flag_errors;
    int                           proto_errors;
    int                           stim_errors;
    int                           timeouts;
    int                           op_count;
    int                           seed;

    icache_top DUT (
        .clk, .rst, .fetch_valid, .fetch_req, .ready, .resp_valid, .fetch_resp,
        .mem_req_valid, .mem_req, .mem_rvalid, .mem_beat, .fence_req, .fence_done
    );

    icache_monitor monitor (
        .clk, .rst, .fetch_valid, .fetch_req, .ready, .resp_valid, .fetch_resp,
        .mem_req_valid, .mem_req, .fence_req, .fence_done, .exp_word, .exp_hit,
        .data_errors, .flag_errors, .proto_errors
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory answers each line request after 0 to 3 idle cycles
    initial begin : memory_model
        logic [`ICACHE_ADDR_BITS-1:0] beat_addr;
        int                           delay;
        mem_rvalid = 1'b0;
        mem_beat   = '0;
        seed       = 32'h0b87e338;
        forever begin
            @(posedge clk);
            if (rst && mem_req_valid) begin
                beat_addr = mem_req.addr;
                delay     = {$random(seed)} % 4;
                repeat (delay) @(posedge clk);
                for (int b = 0; b < `ICACHE_LINE_WORDS; b++) begin
                    mem_rvalid    <= 1'b1;
                    mem_beat.data <= ~beat_addr;
                    mem_beat.last <= (b == `ICACHE_LINE_WORDS - 1);
                    beat_addr     = beat_addr + 32'd4;
                    @(posedge clk);
                end
                mem_rvalid <= 1'b0;
                mem_beat   <= '0;
            end
        end
    end

    task automatic wait_ready(output logic ok);
        ok = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !ok; i++) begin
            @(posedge clk);
            ok = ready;
        end
        if (!ok) begin
            timeouts++;
            $display("timeout at %0t: the cache never became ready", $time);
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic [31:0] word, input logic hit);
        logic ok;
        logic seen;
        wait_ready(ok);
        if (ok) begin
            fetch_valid    <= 1'b1;
            fetch_req.addr <= addr;
            exp_word       <= word;
            exp_hit        <= hit;
            @(posedge clk);
            fetch_valid <= 1'b0;
            seen = 1'b0;
            for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
                @(posedge clk);
                seen = resp_valid;
            end
            if (!seen) begin
                timeouts++;
                $display("timeout at %0t: no response to the fetch of %h", $time, addr);
            end
        end
    endtask

    task automatic run_fence();
        logic ok;
        logic seen;
        wait_ready(ok);
        if (ok) begin
            fence_req <= 1'b1;
            @(posedge clk);
            fence_req <= 1'b0;
            seen = 1'b0;
            for (int i = 0; i < `ICACHE_SETS + 8 && !seen; i++) begin
                @(posedge clk);
                seen = fence_done;
            end
            if (!seen) begin
                timeouts++;
                $display("timeout at %0t: the fence never finished", $time);
            end
        end
    endtask

    initial begin : stimulus
        int          fd;
        int          n;
        string       line;
        logic [39:0] op;
        logic [31:0] addr;
        logic [31:0] word;
        int          hit_flag;
        int          assert_errors;
        rst         = 1'b0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        fence_req   = 1'b0;
        exp_word    = '0;
        exp_hit     = 1'b0;
        stim_errors = 0;
        timeouts    = 0;
        op_count    = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        fd = $fopen("dv/icache_stimulus.txt", "r");
        if (fd == 0) begin
            stim_errors++;
            $display("could not open dv/icache_stimulus.txt");
        end else begin
            while (timeouts == 0 && $fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    op = '0;
                    n  = $sscanf(line, "%s %h %h %d", op, addr, word, hit_flag);
                    op_count++;
                    if (n == 4 && op == "fetch") begin
                        run_fetch(addr, word, hit_flag != 0);
                    end else if (n == 4 && op == "fence") begin
                        run_fence();
                    end else begin
                        stim_errors++;
                        $display("stimulus line not understood: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        if (op_count == 0) begin
            stim_errors++;
            $display("the stimulus file held no operations");
        end
        repeat (4) @(posedge clk);
        assert_errors = DUT.protocol_check.fail_count;
        $display("%0d ops; errors data %0d flag %0d proto %0d assert %0d stim %0d timeout %0d",
                 op_count, data_errors, flag_errors, proto_errors, assert_errors,
                 stim_errors, timeouts);
        if (timeouts == 0 && stim_errors + data_errors + flag_errors + proto_errors
                + assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
`define ICACHE_WAYS         4
`define ICACHE_SETS         16
`define ICACHE_LINE_WORDS   4
`define ICACHE_WORD_BITS    32
`define ICACHE_ADDR_BITS    32

// derived widths
`define ICACHE_SET_BITS     ($clog2(`ICACHE_SETS))
`define ICACHE_WAY_BITS     ($clog2(`ICACHE_WAYS))

// word-in-line bits plus two byte bits
`define ICACHE_OFFSET_BITS  ($clog2(`ICACHE_LINE_WORDS) + 2)

`define ICACHE_TAG_BITS     (`ICACHE_ADDR_BITS - `ICACHE_SET_BITS - `ICACHE_OFFSET_BITS)

`endif

/* hw/icache_pkg.sv */
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    // index types shared by the arrays and the replacement logic
    typedef logic [`ICACHE_SET_BITS-1:0] set_idx_t;
    typedef logic [`ICACHE_WAY_BITS-1:0] way_idx_t;

    // fetch side
    typedef struct packed {
        logic [`ICACHE_ADDR_BITS-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [`ICACHE_WORD_BITS-1:0] word;
    } fetch_resp_t;

    // one tag array entry
    typedef struct packed {
        logic                        valid;
        logic [`ICACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // one cache line, word 0 at the lowest address
    typedef struct packed {
        logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_BITS-1:0] words;
    } line_t;

endpackage

`default_nettype wire

/* hw/icache_plru.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_plru
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     touch,
    input  set_idx_t touch_set,
    input  way_idx_t touch_way,
    input  set_idx_t victim_set,
    output way_idx_t victim_way
);

    // bit 0 picks the half, bit 1 the left pair, bit 2 the right pair
    logic [2:0] tree [`ICACHE_SETS];
    logic [2:0] cur;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                tree[i] <= '0;
            end
        end else if (touch) begin
            // point away from the touched way
            tree[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[touch_set][2] <= ~touch_way[0];
            end else begin
                tree[touch_set][1] <= ~touch_way[0];
            end
        end
    end

    assign cur = tree[victim_set];

    always_comb begin
        if (cur[0]) begin
            victim_way = {1'b1, cur[2]};
        end else begin
            victim_way = {1'b0, cur[1]};
        end
    end

endmodule

`default_nettype wire

/* hw/icache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_refill
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  fetch_req_t miss_addr,
    input  way_idx_t   victim_way,
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_rvalid,
    input  mem_beat_t  mem_beat,
    output logic       fill_valid,
    output line_t      fill_line,
    output way_idx_t   fill_way,
    output set_idx_t   fill_set
);

    localparam int BEAT_BITS = $clog2(`ICACHE_LINE_WORDS);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        STREAM
    } refill_state_e;

    refill_state_e          state;
    logic [BEAT_BITS-1:0]   beat_cnt;
    logic                   beat_take;

    // beats may already arrive while the request strobe is out
    assign beat_take = mem_rvalid && (state != IDLE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= IDLE;
            beat_cnt   <= '0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= beat_take && mem_beat.last;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= REQUEST;
                        beat_cnt <= '0;
                    end
                end
                REQUEST: begin
                    state <= STREAM;
                end
                default: ;
            endcase
            if (beat_take) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (mem_beat.last) begin
                    state <= IDLE;
                end
            end
        end
    end

    // miss address and victim held for the whole refill
    always_ff @(posedge clk) begin
        if (start && state == IDLE) begin
            mem_req.addr <= {miss_addr.addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
                             {(`ICACHE_OFFSET_BITS){1'b0}}};
            fill_way     <= victim_way;
        end
        if (beat_take) begin
            fill_line.words[beat_cnt] <= mem_beat.data;
        end
    end

    assign mem_req_valid = (state == REQUEST);
    assign fill_set      = mem_req.addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];

endmodule

`default_nettype wire

/* hw/icache_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_sram
    import icache_pkg::*;
#(
    parameter type entry_t = tag_entry_t
) (
    input  logic     clk,
    input  logic     rst,
    input  set_idx_t rd_index,
    output entry_t   rd_data,
    input  logic     we,
    input  set_idx_t wr_index,
    input  entry_t   wr_data
);

    entry_t mem [`ICACHE_SETS];

    // registered read, old data on a same-index write
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (we) begin
                mem[wr_index] <= wr_data;
            end
            rd_data <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    input  fetch_req_t  fetch_req,
    output logic        ready,
    output logic        resp_valid,
    output fetch_resp_t fetch_resp,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_rvalid,
    input  mem_beat_t   mem_beat,
    input  logic        fence_req,
    output logic        fence_done
);

    localparam int WORD_SEL_BITS = `ICACHE_OFFSET_BITS - 2;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS
    } lookup_state_e;

    lookup_state_e               state;
    fetch_req_t                  req_q;
    set_idx_t                    rd_set;
    set_idx_t                    req_set;
    logic [`ICACHE_TAG_BITS-1:0] req_tag;
    logic [WORD_SEL_BITS-1:0]    word_sel;

    tag_entry_t                  tag_rd [`ICACHE_WAYS];
    line_t                       data_rd [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]     way_hit;
    logic [`ICACHE_WAYS-1:0]     tag_we;
    logic [`ICACHE_WAYS-1:0]     data_we;
    logic                        hit_any;
    way_idx_t                    hit_way;
    set_idx_t                    tag_wr_set;
    tag_entry_t                  tag_wr_data;

    logic                        touch;
    set_idx_t                    touch_set;
    way_idx_t                    touch_way;
    way_idx_t                    victim_way;
    logic                        refill_start;
    logic                        fill_valid;
    line_t                       fill_line;
    way_idx_t                    fill_way;
    set_idx_t                    fill_set;

    logic                        fence_active;
    set_idx_t                    fence_idx;

    assign ready    = (state == IDLE) && !fence_active;
    assign rd_set   = fetch_req.addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign req_set  = req_q.addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign req_tag  = req_q.addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
    assign word_sel = req_q.addr[`ICACHE_OFFSET_BITS-1:2];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (fetch_valid && ready) state <= LOOKUP;
                LOOKUP:  state <= hit_any ? IDLE : MISS;
                MISS:    if (fill_valid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && ready) begin
            req_q <= fetch_req;
        end
    end

    // fence clears one set per cycle in every way
    assign tag_wr_set        = fence_active ? fence_idx : fill_set;
    assign tag_wr_data.valid = !fence_active;
    assign tag_wr_data.tag   = req_tag;

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        assign data_we[w] = fill_valid && (fill_way == way_idx_t'(w));
        assign tag_we[w]  = fence_active || data_we[w];
        assign way_hit[w] = tag_rd[w].valid && (tag_rd[w].tag == req_tag);

        icache_sram #(.entry_t(tag_entry_t)) tag_ram (
            .clk, .rst, .rd_index(rd_set), .rd_data(tag_rd[w]),
            .we(tag_we[w]), .wr_index(tag_wr_set), .wr_data(tag_wr_data)
        );

        icache_sram #(.entry_t(line_t)) data_ram (
            .clk, .rst, .rd_index(rd_set), .rd_data(data_rd[w]),
            .we(data_we[w]), .wr_index(fill_set), .wr_data(fill_line)
        );
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) hit_way = way_idx_t'(w);
        end
    end

    assign hit_any      = |way_hit;
    assign refill_start = (state == LOOKUP) && !hit_any;
    assign resp_valid   = ((state == LOOKUP) && hit_any) || ((state == MISS) && fill_valid);

    // refill forwards the word straight from the assembled line
    assign fetch_resp.word = (state == MISS) ? fill_line.words[word_sel]
                                             : data_rd[hit_way].words[word_sel];

    assign touch     = ((state == LOOKUP) && hit_any) || fill_valid;
    assign touch_set = fill_valid ? fill_set : req_set;
    assign touch_way = fill_valid ? fill_way : hit_way;

    icache_plru plru (
        .clk, .rst, .touch, .touch_set, .touch_way,
        .victim_set(req_set), .victim_way
    );

    icache_refill refill (
        .clk, .rst, .start(refill_start), .miss_addr(req_q), .victim_way,
        .mem_req_valid, .mem_req, .mem_rvalid, .mem_beat,
        .fill_valid, .fill_line, .fill_way, .fill_set
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fence_active <= 1'b0;
            fence_idx    <= '0;
            fence_done   <= 1'b0;
        end else begin
            if (fence_req) fence_active <= 1'b1;
            if (fence_active) begin
                fence_idx <= fence_idx + 1'b1;
                if (&fence_idx) fence_active <= 1'b0;
            end
            fence_done <= fence_active && (&fence_idx);
        end
    end

endmodule

`default_nettype wire

/* hw/mem_bus_pkg.sv */
`default_nettype none

`include "icache_defines.svh"

package mem_bus_pkg;

    // line-aligned read request
    typedef struct packed {
        logic [`ICACHE_ADDR_BITS-1:0] addr;
    } mem_req_t;

    // one read beat
    typedef struct packed {
        logic [`ICACHE_WORD_BITS-1:0] data;
        logic                         last;
    } mem_beat_t;

endpackage

`default_nettype wire

/* project.f */
+incdir+hw
hw/icache_pkg.sv
hw/mem_bus_pkg.sv
hw/icache_sram.sv
hw/icache_plru.sv
hw/icache_refill.sv
hw/icache_top.sv
dv/icache_checker.sv
dv/icache_monitor.sv
dv/icache_tb.sv
